// File: Makefile
# Verilator build and run for the packed ALU testbench

VERILATOR ?= verilator
TOP       ?= palu_tb
RTL_TOP   ?= palu_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= === PASS ===
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF -- "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: palu_adder.sv
// Packed adder
// Add or subtract with the carry chain cut at each lane boundary
`timescale 1ns/1ps
`default_nettype none

module palu_adder (
    input  wire palu_pkg::word_t a_i,    // LHS
    input  wire palu_pkg::word_t b_i,    // RHS
    input  wire palu_pkg::pw_t   pw_i,   // Pack width
    input  wire                  sub_i,  // a - b
    output palu_pkg::word_t      c_o     // Lane sums
);

    logic [5:0]      lw;    // Lane width
    palu_pkg::word_t b_op;  // b, inverted on subtract

    assign lw   = palu_pkg::lane_width(pw_i);
    assign b_op = sub_i ? ~b_i : b_i;

    // Ripple chain, reseeded at every lane bottom
    always_comb begin
        logic carry;
        carry = 1'b0;
        for (int i = 0; i < $bits(palu_pkg::word_t); i++) begin
            if ((i & (lw - 6'd1)) == 0) begin
                carry = sub_i;                // +1 completes two's complement
            end
            c_o[i] = a_i[i] ^ b_op[i] ^ carry;
            carry  = (a_i[i] & b_op[i]) | (carry & (a_i[i] ^ b_op[i]));
        end
    end

endmodule

`default_nettype wire

// File: palu_assertions.sv
// Packed ALU protocol checks
// Done only with valid, enable shape, multiply done within the cycle limit
`timescale 1ns/1ps
`default_nettype none
`include "palu_settings.svh"

module palu_assertions (
    input wire                 g_clk,
    input wire                 rst_i,
    input wire                 valid_i,
    input wire                 done_i,
    input wire palu_pkg::ben_t ben_i,
    input wire                 mul_start_i,
    input wire                 mul_done_i
);

    int  mul_cnt_q;   // Cycles since start
    logic mul_open_q; // Multiply in flight

    always_ff @(posedge g_clk) begin
        if (rst_i) begin
            mul_open_q <= 1'b0;
            mul_cnt_q  <= 0;
        end else if (mul_start_i) begin
            mul_open_q <= 1'b1;
            mul_cnt_q  <= 1;
        end else if (mul_done_i) begin
            mul_open_q <= 1'b0;
        end else if (mul_open_q) begin
            mul_cnt_q  <= mul_cnt_q + 1;
        end
    end

    done_needs_valid: assert property (@(posedge g_clk) disable iff (rst_i)
        done_i |-> valid_i)
        else $error("done high without valid");

    ben_shape: assert property (@(posedge g_clk) disable iff (rst_i)
        ben_i == 4'h0 || ben_i == 4'hF)
        else $error("partial byte enable");

    ben_only_on_done: assert property (@(posedge g_clk) disable iff (rst_i)
        !done_i |-> ben_i == 4'h0)
        else $error("byte enable without done");

    mul_in_time: assert property (@(posedge g_clk) disable iff (rst_i)
        mul_open_q |-> mul_cnt_q <= `PALU_MUL_TIMEOUT)
        else $error("multiply done late");

endmodule

bind palu_top palu_assertions u_palu_assertions (
    .g_clk      (g_clk),
    .rst_i      (rst_i),
    .valid_i    (palu_ivalid_i),
    .done_i     (palu_idone_o),
    .ben_i      (palu_rd_ben_o),
    .mul_start_i(mul_start),
    .mul_done_i (mul_done)
);

`default_nettype wire

// File: palu_bitwise.sv
// Bitwise and twiddle results
// bop lookup, bit-field ext and ins, load immediates, byte permute
`timescale 1ns/1ps
`default_nettype none
`include "palu_settings.svh"

module palu_bitwise (
    input  wire palu_pkg::palu_op_t op_i,
    input  wire palu_pkg::word_t    rs1_i,
    input  wire palu_pkg::word_t    rs2_i,
    input  wire palu_pkg::word_t    rs3_i,     // Old crd value
    output palu_pkg::word_t         result_o
);

    logic            is_bw;      // Bitwise class
    logic [4:0]      ei_start;   // Field start, even
    logic [4:0]      ei_len;     // Field length, even
    palu_pkg::word_t ei_mask;    // Ones in the low ei_len bits
    palu_pkg::word_t bop_res;
    palu_pkg::word_t ext_res;
    palu_pkg::word_t ins_res;
    palu_pkg::word_t twid_res;

    assign is_bw = op_i.iclass == palu_pkg::BITWISE;

    // Truth table indexed by {rs1, rs2} bit pair
    always_comb begin
        for (int i = 0; i < $bits(palu_pkg::word_t); i++) begin
            bop_res[i] = op_i.imm[{rs1_i[i], rs2_i[i]}];
        end
    end

    // ------------------------------------------------------------------------
    // Bit-field extract and insert
    // ------------------------------------------------------------------------
    assign ei_start = {op_i.imm[7:4], 1'b0};
    assign ei_len   = {op_i.imm[3:0], 1'b0};
    assign ei_mask  = ~('1 << ei_len);           // len 0 gives empty field
    assign ext_res  = (rs1_i >> ei_start) & ei_mask;
    assign ins_res  = ((rs1_i & ei_mask) << ei_start) |
                      (rs3_i & ~(ei_mask << ei_start));

    // Byte k takes rs1 byte imm[2k+1:2k]
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            twid_res[8*k +: 8] = rs1_i[8*op_i.imm[2*k +: 2] +: 8];
        end
    end

    // Result select
    always_comb begin
        result_o = '0;
        if (is_bw) begin
            case (op_i.subclass)
                `PALU_SC_BOP:   result_o = bop_res;
                `PALU_SC_EXT:   result_o = ext_res;
                `PALU_SC_INS:   result_o = ins_res;
                `PALU_SC_LD_LI: result_o = {rs3_i[31:16], op_i.imm[15:0]};
                `PALU_SC_LD_HI: result_o = {op_i.imm[15:0], rs3_i[15:0]};
                default:        result_o = '0;
            endcase
        end else if (op_i.iclass == palu_pkg::TWIDDLE &&
                     op_i.subclass == `PALU_SC_TWID_B) begin
            result_o = twid_res;
        end
    end

endmodule

`default_nettype wire

// File: palu_multiplier.sv
// Packed multiplier, low half only
// Shift-and-add, one step per lane bit, using the shared adder and shifter
`timescale 1ns/1ps
`default_nettype none

module palu_multiplier (
    input  wire                     g_clk,
    input  wire                     rst_i,
    input  wire                     start_i,   // One-cycle start pulse
    input  wire palu_pkg::pw_t      pw_i,      // Pack width, held
    input  wire palu_pkg::word_t    a_i,       // Multiplicand
    input  wire palu_pkg::word_t    b_i,       // Multiplier
    input  wire palu_pkg::shr_rsp_t rsp_i,     // Shared unit results
    output palu_pkg::shr_req_t      req_o,     // Shared unit request
    output logic                    busy_o,
    output logic                    done_o,    // One-cycle pulse
    output palu_pkg::word_t         result_o   // Valid with done_o
);

    palu_pkg::mul_state_e state_q;
    logic [4:0]           cnt_q;     // Step counter
    logic [5:0]           lw;        // Lane width
    logic                 last_step;
    palu_pkg::word_t      acc_q;     // Partial products
    palu_pkg::word_t      mcand_q;   // Multiplicand, shifted left per step
    palu_pkg::word_t      b_q;       // Multiplier, shifted right per step
    palu_pkg::word_t      bit_mask;  // Lane-wide copy of current b bit

    assign lw        = palu_pkg::lane_width(pw_i);
    assign last_step = cnt_q == 5'(lw - 6'd1);

    // After i steps the lane bottom of b_q holds original bit i of that lane
    always_comb begin
        for (int j = 0; j < $bits(palu_pkg::word_t); j++) begin
            bit_mask[j] = b_q[j & ~(int'(lw) - 1)];
        end
    end

    // acc + (mcand & mask), mcand << 1 per lane
    always_comb begin
        req_o.add_a     = acc_q;
        req_o.add_b     = mcand_q & bit_mask;
        req_o.add_sub   = 1'b0;
        req_o.shf_a     = mcand_q;
        req_o.shf_shamt = 5'd1;
        req_o.shf_left  = 1'b1;
        req_o.shf_rot   = 1'b0;
    end

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (rst_i) begin
            state_q <= palu_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                palu_pkg::IDLE: if (start_i) begin
                    state_q <= palu_pkg::STEP;
                    cnt_q   <= '0;
                end
                palu_pkg::STEP: begin
                    cnt_q <= cnt_q + 5'd1;
                    if (last_step) state_q <= palu_pkg::DONE;
                end
                default: state_q <= palu_pkg::IDLE;  // DONE lasts one cycle
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge g_clk) begin
        if (state_q == palu_pkg::IDLE && start_i) begin
            acc_q   <= '0;
            mcand_q <= a_i;
            b_q     <= b_i;
        end else if (state_q == palu_pkg::STEP) begin
            acc_q   <= rsp_i.add_c;
            mcand_q <= rsp_i.shf_c;
            b_q     <= b_q >> 1;  // Cross-lane bits never reach a lane bottom
        end
    end

    assign busy_o   = state_q != palu_pkg::IDLE;
    assign done_o   = state_q == palu_pkg::DONE;
    assign result_o = acc_q;

endmodule

`default_nettype wire

// File: palu_pkg.sv
// Packed ALU types
// Data vectors, decode enums, shared-unit request and response
`default_nettype none
`include "palu_settings.svh"

package palu_pkg;

    typedef logic [`PALU_XLEN-1:0] word_t;     // Data word
    typedef logic [3:0]            ben_t;      // Writeback byte enable
    typedef logic [2:0]            pw_t;       // Pack width code
    typedef logic [3:0]            subclass_t; // Subclass within a class

    // Instruction class
    typedef enum logic [2:0] {
        MOVE    = 3'b001,
        BITWISE = 3'b010,
        PARITH  = 3'b011,
        TWIDDLE = 3'b100
    } iclass_e;

    // Multiplier FSM
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        STEP = 2'b01,
        DONE = 2'b10
    } mul_state_e;

    // Decoded operation, 42 bits
    typedef struct packed {
        iclass_e   iclass;
        subclass_t subclass;
        pw_t       pw;
        word_t     imm;
    } palu_op_t;

    // Request to the shared adder and shifter, 104 bits
    typedef struct packed {
        word_t      add_a;
        word_t      add_b;
        logic       add_sub;   // Subtract instead of add
        word_t      shf_a;
        logic [4:0] shf_shamt;
        logic       shf_left;  // Left, else right
        logic       shf_rot;   // Rotate, else shift
    } shr_req_t;

    // Shared unit results, 64 bits
    typedef struct packed {
        word_t add_c;
        word_t shf_c;
    } shr_rsp_t;

    // Lane width in bits for a pack width code
    function automatic logic [5:0] lane_width(pw_t pw);
        case (pw)
            `PALU_PW_16: return 6'd16;
            `PALU_PW_8:  return 6'd8;
            `PALU_PW_4:  return 6'd4;
            `PALU_PW_2:  return 6'd2;
            default:     return 6'd32;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: palu_settings.svh
// Packed ALU settings
// Data width, pack-width and subclass codes, multiply cycle limit
`ifndef PALU_SETTINGS_SVH
`define PALU_SETTINGS_SVH

`define PALU_XLEN         32              // Datapath width

// Pack width codes, lane size in bits
`define PALU_PW_32        3'b000
`define PALU_PW_16        3'b001
`define PALU_PW_8         3'b010
`define PALU_PW_4         3'b011
`define PALU_PW_2         3'b100

// Subclass codes, unique only within their class
`define PALU_SC_CMOV      4'h0            // Move class
`define PALU_SC_CMOVN     4'h1
`define PALU_SC_GPR2XCR   4'h2
`define PALU_SC_BOP       4'h2            // Bitwise class, 0 and 1 were mix
`define PALU_SC_EXT       4'h3
`define PALU_SC_INS       4'h4
`define PALU_SC_LD_LI     4'h5
`define PALU_SC_LD_HI     4'h6
`define PALU_SC_TWID_B    4'h0            // Twiddle class
`define PALU_SC_PADD      4'h0            // Packed arithmetic class
`define PALU_SC_PSUB      4'h1
`define PALU_SC_PMUL_L    4'h2
`define PALU_SC_PSLL      4'h4
`define PALU_SC_PSRL      4'h5
`define PALU_SC_PROT      4'h6
`define PALU_SC_PSLL_I    4'h7
`define PALU_SC_PSRL_I    4'h8
`define PALU_SC_PROT_I    4'h9

`define PALU_MUL_TIMEOUT  40              // Max cycles from start to done

`endif

// File: palu_share_arb.sv
// Shared unit arbiter
// Owns the packed adder and shifter, grants them to direct path or multiplier
`timescale 1ns/1ps
`default_nettype none

module palu_share_arb (
    input  wire                     g_clk,
    input  wire                     rst_i,
    input  wire palu_pkg::shr_req_t dir_req_i,    // Direct arithmetic path
    input  wire palu_pkg::shr_req_t mul_req_i,    // Multiplier steps
    input  wire                     mul_start_i,
    input  wire                     mul_done_i,
    input  wire                     mul_busy_i,
    input  wire palu_pkg::pw_t      pw_i,
    output palu_pkg::shr_rsp_t      rsp_o         // Seen by both peers
);

    logic               grant_mul_q;  // Registered grant
    logic               sel_mul;
    palu_pkg::shr_req_t req;
    palu_pkg::word_t    add_c;
    palu_pkg::word_t    shf_c;

    // Take on start, give back the cycle after done
    always_ff @(posedge g_clk) begin
        if (rst_i) begin
            grant_mul_q <= 1'b0;
        end else if (mul_start_i) begin
            grant_mul_q <= 1'b1;
        end else if (mul_done_i) begin
            grant_mul_q <= 1'b0;
        end
    end

    assign sel_mul = grant_mul_q & mul_busy_i;
    assign req     = sel_mul ? mul_req_i : dir_req_i;

    palu_adder i_palu_adder (
        .a_i  (req.add_a),
        .b_i  (req.add_b),
        .pw_i (pw_i),
        .sub_i(req.add_sub),
        .c_o  (add_c)
    );

    palu_shifter i_palu_shifter (
        .a_i    (req.shf_a),
        .shamt_i(req.shf_shamt),
        .pw_i   (pw_i),
        .left_i (req.shf_left),
        .rot_i  (req.shf_rot),
        .c_o    (shf_c)
    );

    assign rsp_o = '{add_c: add_c, shf_c: shf_c};

endmodule

`default_nettype wire

// File: palu_shifter.sv
// Packed shifter
// Per-lane logical shift or rotate, amount taken modulo the lane width
`timescale 1ns/1ps
`default_nettype none

module palu_shifter (
    input  wire palu_pkg::word_t a_i,      // Operand
    input  wire [4:0]            shamt_i,  // Shift amount
    input  wire palu_pkg::pw_t   pw_i,     // Pack width
    input  wire                  left_i,   // Left, else right
    input  wire                  rot_i,    // Rotate, else shift
    output palu_pkg::word_t      c_o
);

    logic [5:0] lw;  // Lane width

    assign lw = palu_pkg::lane_width(pw_i);

    // Each result bit picks its source offset inside its own lane
    always_comb begin
        int lane;  // Lane width as int
        int amt;   // Effective amount
        int off;   // Offset of bit j in its lane
        int base;  // Bottom bit of that lane
        int src;   // Source offset, may fall outside the lane
        lane = int'(lw);
        amt  = int'(shamt_i) & (lane - 1);
        for (int j = 0; j < $bits(palu_pkg::word_t); j++) begin
            off  = j & (lane - 1);
            base = j - off;
            src  = left_i ? off - amt : off + amt;
            if (src >= 0 && src < lane) begin
                c_o[j] = a_i[base + src];
            end else if (rot_i) begin
                c_o[j] = a_i[base + (src & (lane - 1))];  // Wrap in lane
            end else begin
                c_o[j] = 1'b0;                            // Shifted-in zero
            end
        end
    end

endmodule

`default_nettype wire

// File: palu_tb.sv
// Packed ALU testbench
// Directed tests per class, checked against a lane-by-lane reference model
`timescale 1ns/1ps
`default_nettype none
`include "palu_settings.svh"

module palu_tb;

    logic               g_clk;
    logic               rst_i;
    logic               valid;
    palu_pkg::palu_op_t op;
    palu_pkg::word_t    gpr, rs1, rs2, rs3;
    logic               done;
    palu_pkg::ben_t     ben;
    palu_pkg::word_t    wdata;
    int                 errors;
    int                 seed;

    palu_top DUT (
        .g_clk          (g_clk),
        .rst_i          (rst_i),
        .palu_ivalid_i  (valid),
        .palu_op_i      (op),
        .gpr_rs1_i      (gpr),
        .palu_rs1_i     (rs1),
        .palu_rs2_i     (rs2),
        .palu_rs3_i     (rs3),
        .palu_idone_o   (done),
        .palu_rd_ben_o  (ben),
        .palu_rd_wdata_o(wdata)
    );

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;             // 4 ns period
    end

    // ------------------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------------------
    function automatic int width_of(logic [2:0] pw);
        case (pw)
            `PALU_PW_16: return 16;
            `PALU_PW_8:  return 8;
            `PALU_PW_4:  return 4;
            `PALU_PW_2:  return 2;
            default:     return 32;
        endcase
    endfunction

    // Each lane computed on its own so a leaking carry shows up
    function automatic logic [31:0] parith_ref(logic [3:0] sc, logic [2:0] pw,
                                               logic [31:0] a, logic [31:0] b,
                                               logic [4:0] amt);
        int          w;
        int          s;
        logic [63:0] m, x, y, r;
        logic [31:0] res;
        w   = width_of(pw);
        m   = (64'd1 << w) - 64'd1;
        s   = int'(amt) % w;                   // Amount modulo lane width
        res = '0;
        for (int l = 0; l < 32 / w; l++) begin
            x = ({32'd0, a} >> (l * w)) & m;
            y = ({32'd0, b} >> (l * w)) & m;
            case (sc)
                `PALU_SC_PADD:                  r = x + y;
                `PALU_SC_PSUB:                  r = x - y;
                `PALU_SC_PMUL_L:                r = x * y;
                `PALU_SC_PSLL, `PALU_SC_PSLL_I: r = x << s;
                `PALU_SC_PSRL, `PALU_SC_PSRL_I: r = x >> s;
                default:                        r = (x >> s) | (x << (w - s));  // Rotate right
            endcase
            res = res | 32'((r & m) << (l * w));
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("Closing: %0d error(s)", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // Drive one op, wait for done, sample at the falling edge, drop valid
    task automatic run_op(input palu_pkg::iclass_e ic, input logic [3:0] sc,
                          input logic [2:0] pw, input logic [31:0] imm,
                          input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] c, input logic [31:0] g,
                          output logic [31:0] data, output logic [3:0] be,
                          output int cycles);
        @(posedge g_clk);
        #1;
        op.iclass   = ic;
        op.subclass = sc;
        op.pw       = pw;
        op.imm      = imm;
        rs1         = a;
        rs2         = b;
        rs3         = c;
        gpr         = g;
        valid       = 1'b1;
        cycles      = 0;
        @(negedge g_clk);
        while (!done && cycles < `PALU_MUL_TIMEOUT) begin
            @(negedge g_clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout: done never rose within %0d cycles", cycles);
            errors++;
            finish_run();
        end else begin
            data = wdata;
            be   = ben;
            @(posedge g_clk);
            #1;
            valid = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_moves();
        logic [3:0]  sc;
        logic [31:0] a, g, z, d;
        logic [3:0]  be;
        int          cyc;
        logic        en;
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < 3; k++) begin
                sc = (k == 0) ? `PALU_SC_CMOV : (k == 1) ? `PALU_SC_CMOVN : `PALU_SC_GPR2XCR;
                a  = $random(seed);
                g  = $random(seed);
                z  = (r == 0) ? 32'd0 : ($random(seed) | 32'd1);  // Zero on the first pass
                en = (k == 2) || ((k == 0) == (r == 0));  // cmov wants zero, cmovn nonzero
                run_op(palu_pkg::MOVE, sc, `PALU_PW_32, '0, a, z, '0, g, d, be, cyc);
                check_value("palu_rd_ben_o", en ? 32'hF : 32'h0, 32'(be));
                if (en) check_value("palu_rd_wdata_o", (k == 2) ? g : a, d);
                check_value("done latency", 32'd0, 32'(cyc));  // Same cycle as valid
            end
        end
    endtask

    task automatic test_bitwise();
        logic [31:0] a, b, c, d, e, x_exp;
        logic [31:0] tt [3];
        logic [7:0]  fld [5];
        logic [3:0]  be;
        int          cyc;
        int          st;
        int          ln;
        tt  = '{32'h8, 32'h6, 32'hE};             // AND, XOR, OR
        fld = '{8'h24, 8'h58, 8'hF1, 8'h0F, 8'h3A};
        foreach (tt[t]) begin
            a = $random(seed);
            b = $random(seed);
            for (int i = 0; i < 32; i++) e[i] = tt[t][2 * a[i] + b[i]];
            run_op(palu_pkg::BITWISE, `PALU_SC_BOP, '0, tt[t], a, b, '0, '0, d, be, cyc);
            check_value("palu_rd_wdata_o bop", e, d);
        end
        foreach (fld[f]) begin
            a  = $random(seed);
            c  = $random(seed);
            st = 2 * int'(fld[f][7:4]);
            ln = 2 * int'(fld[f][3:0]);
            // Field of ln bits starting at bit st, bit by bit
            for (int i = 0; i < 32; i++) begin
                x_exp[i] = (i < ln && st + i < 32) ? a[st + i] : 1'b0;
                e[i]     = (i >= st && i < st + ln) ? a[i - st] : c[i];
            end
            run_op(palu_pkg::BITWISE, `PALU_SC_EXT, '0, 32'(fld[f]), a, '0, c, '0, d, be, cyc);
            check_value("palu_rd_wdata_o ext", x_exp, d);
            run_op(palu_pkg::BITWISE, `PALU_SC_INS, '0, 32'(fld[f]), a, '0, c, '0, d, be, cyc);
            check_value("palu_rd_wdata_o ins", e, d);
        end
        a = $random(seed);
        c = $random(seed);
        run_op(palu_pkg::BITWISE, `PALU_SC_LD_LI, '0, a, '0, '0, c, '0, d, be, cyc);
        check_value("palu_rd_wdata_o ld_li", {c[31:16], a[15:0]}, d);
        run_op(palu_pkg::BITWISE, `PALU_SC_LD_HI, '0, a, '0, '0, c, '0, d, be, cyc);
        check_value("palu_rd_wdata_o ld_hi", {a[15:0], c[15:0]}, d);
    endtask

    task automatic test_twiddle();
        logic [31:0] a, d, e, imm;
        logic [3:0]  be;
        int          cyc;
        int          sel;
        for (int t = 0; t < 8; t++) begin
            case (t)
                0:       imm = 32'hE4;            // Identity
                1:       imm = 32'h1B;            // Byte reverse
                2:       imm = 32'h00;            // Broadcast byte 0
                3:       imm = 32'hFF;            // Broadcast byte 3
                default: imm = $random(seed);
            endcase
            a = $random(seed);
            for (int k = 0; k < 4; k++) begin
                sel           = int'(imm[2 * k +: 2]);
                e[8 * k +: 8] = a[8 * sel +: 8];
            end
            run_op(palu_pkg::TWIDDLE, `PALU_SC_TWID_B, '0, imm, a, '0, '0, '0, d, be, cyc);
            check_value("palu_rd_wdata_o twid_b", e, d);
        end
    endtask

    // Add, subtract and all shift forms with amounts from rs2 or imm
    task automatic test_direct_arith();
        logic [3:0]  scs [8];
        logic [31:0] a, b, d;
        logic [4:0]  amt;
        logic [3:0]  be;
        int          cyc;
        logic        imm_form;
        scs = '{`PALU_SC_PADD, `PALU_SC_PSUB, `PALU_SC_PSLL, `PALU_SC_PSRL,
                `PALU_SC_PROT, `PALU_SC_PSLL_I, `PALU_SC_PSRL_I, `PALU_SC_PROT_I};
        for (int p = 0; p < 5; p++) begin
            foreach (scs[s]) begin
                for (int n = 0; n < 3; n++) begin
                    a        = $random(seed);
                    b        = $random(seed);
                    amt      = (n == 0) ? 5'd1 : (n == 1) ? 5'd31 : 5'($random(seed));
                    imm_form = s >= 5;
                    if (!imm_form) b[4:0] = amt;
                    run_op(palu_pkg::PARITH, scs[s], 3'(p), imm_form ? 32'(amt) : 32'h0,
                           a, b, '0, '0, d, be, cyc);
                    check_value("palu_rd_wdata_o parith",
                                parith_ref(scs[s], 3'(p), a, b, amt), d);
                    check_value("palu_rd_ben_o", 32'hF, 32'(be));
                end
            end
        end
    endtask

    task automatic test_pmul();
        logic [31:0] a, b, d;
        logic [3:0]  be;
        int          cyc;
        for (int p = 0; p < 5; p++) begin
            for (int n = 0; n < 3; n++) begin
                a = $random(seed);
                b = $random(seed);
                run_op(palu_pkg::PARITH, `PALU_SC_PMUL_L, 3'(p), '0, a, b, '0, '0, d, be, cyc);
                check_value("palu_rd_wdata_o pmul",
                            parith_ref(`PALU_SC_PMUL_L, 3'(p), a, b, '0), d);
                check_value("pmul done latency", 32'(width_of(3'(p)) + 1), 32'(cyc));
                // Adder must be back on the direct path
                a = $random(seed);
                b = $random(seed);
                run_op(palu_pkg::PARITH, `PALU_SC_PADD, 3'(p), '0, a, b, '0, '0, d, be, cyc);
                check_value("palu_rd_wdata_o padd after pmul",
                            parith_ref(`PALU_SC_PADD, 3'(p), a, b, '0), d);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        errors = 0;
        seed   = 32'h0541_44b0;
        rst_i  = 1'b1;
        valid  = 1'b0;
        op     = '0;
        gpr    = '0;
        rs1    = '0;
        rs2    = '0;
        rs3    = '0;
        repeat (4) @(posedge g_clk);
        #1;
        rst_i = 1'b0;
        check_value("palu_idone_o after reset", 32'h0, 32'(done));
        check_value("palu_rd_ben_o after reset", 32'h0, 32'(ben));
        test_moves();
        test_bitwise();
        test_twiddle();
        test_direct_arith();
        test_pmul();
        finish_run();
    end

endmodule

`default_nettype wire

// File: palu_top.sv
// Packed ALU top level
// Class decode, conditional moves, shared-unit request, writeback select
`timescale 1ns/1ps
`default_nettype none
`include "palu_settings.svh"

module palu_top (
    input  wire                     g_clk,
    input  wire                     rst_i,
    input  wire                     palu_ivalid_i,   // Held until done
    input  wire palu_pkg::palu_op_t palu_op_i,       // Decoded operation
    input  wire palu_pkg::word_t    gpr_rs1_i,       // GPR source, gpr2xcr
    input  wire palu_pkg::word_t    palu_rs1_i,
    input  wire palu_pkg::word_t    palu_rs2_i,
    input  wire palu_pkg::word_t    palu_rs3_i,      // Old crd value
    output logic                    palu_idone_o,
    output palu_pkg::ben_t          palu_rd_ben_o,
    output palu_pkg::word_t         palu_rd_wdata_o
);

    palu_pkg::subclass_t sc;
    logic is_move;
    logic is_parith;
    logic is_other;                  // Bitwise or twiddle
    logic is_padd;
    logic is_psub;
    logic is_pmul;
    logic shift_imm;                 // Amount from the immediate
    logic cmov_cond;                 // rs2 is zero
    logic wen_move;
    logic mul_started_q;             // Start already issued
    logic mul_start;
    logic mul_done;
    logic mul_busy;
    palu_pkg::word_t    mul_result;
    palu_pkg::word_t    result_bitwise;
    palu_pkg::word_t    result_parith;
    palu_pkg::shr_req_t dir_req;
    palu_pkg::shr_req_t mul_req;
    palu_pkg::shr_rsp_t shr_rsp;

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------
    assign sc        = palu_op_i.subclass;
    assign is_move   = palu_ivalid_i && palu_op_i.iclass == palu_pkg::MOVE;
    assign is_parith = palu_ivalid_i && palu_op_i.iclass == palu_pkg::PARITH;
    assign is_other  = palu_ivalid_i && (palu_op_i.iclass == palu_pkg::BITWISE ||
                                         palu_op_i.iclass == palu_pkg::TWIDDLE);
    assign is_padd   = is_parith && sc == `PALU_SC_PADD;
    assign is_psub   = is_parith && sc == `PALU_SC_PSUB;
    assign is_pmul   = is_parith && sc == `PALU_SC_PMUL_L;
    assign shift_imm = sc == `PALU_SC_PSLL_I || sc == `PALU_SC_PSRL_I ||
                       sc == `PALU_SC_PROT_I;

    // Conditional moves
    assign cmov_cond = palu_rs2_i == '0;
    assign wen_move  = sc == `PALU_SC_GPR2XCR ||
                       (sc == `PALU_SC_CMOV  &&  cmov_cond) ||
                       (sc == `PALU_SC_CMOVN && !cmov_cond);

    // Direct request, ignored while the multiplier holds the grant
    always_comb begin
        dir_req.add_a     = palu_rs1_i;
        dir_req.add_b     = palu_rs2_i;
        dir_req.add_sub   = is_psub;
        dir_req.shf_a     = palu_rs1_i;
        dir_req.shf_shamt = shift_imm ? palu_op_i.imm[4:0] : palu_rs2_i[4:0];
        dir_req.shf_left  = sc == `PALU_SC_PSLL || sc == `PALU_SC_PSLL_I;
        dir_req.shf_rot   = sc == `PALU_SC_PROT || sc == `PALU_SC_PROT_I;
    end

    // ------------------------------------------------------------------------
    // Multiply start, one pulse per operation
    // ------------------------------------------------------------------------
    assign mul_start = is_pmul && !mul_started_q;

    always_ff @(posedge g_clk) begin
        if (rst_i) begin
            mul_started_q <= 1'b0;
        end else if (!palu_ivalid_i || palu_idone_o) begin
            mul_started_q <= 1'b0;           // Rearm for the next op
        end else if (mul_start) begin
            mul_started_q <= 1'b1;
        end
    end

    palu_multiplier i_palu_multiplier (
        .g_clk   (g_clk),
        .rst_i   (rst_i),
        .start_i (mul_start),
        .pw_i    (palu_op_i.pw),
        .a_i     (palu_rs1_i),
        .b_i     (palu_rs2_i),
        .rsp_i   (shr_rsp),
        .req_o   (mul_req),
        .busy_o  (mul_busy),
        .done_o  (mul_done),
        .result_o(mul_result)
    );

    palu_share_arb i_palu_share_arb (
        .g_clk      (g_clk),
        .rst_i      (rst_i),
        .dir_req_i  (dir_req),
        .mul_req_i  (mul_req),
        .mul_start_i(mul_start),
        .mul_done_i (mul_done),
        .mul_busy_i (mul_busy),
        .pw_i       (palu_op_i.pw),
        .rsp_o      (shr_rsp)
    );

    palu_bitwise i_palu_bitwise (
        .op_i    (palu_op_i),
        .rs1_i   (palu_rs1_i),
        .rs2_i   (palu_rs2_i),
        .rs3_i   (palu_rs3_i),
        .result_o(result_bitwise)
    );

    // Adder for padd/psub, shifter for the rest
    assign result_parith = is_pmul             ? mul_result    :
                           (is_padd || is_psub) ? shr_rsp.add_c :
                                                  shr_rsp.shf_c;

    // ------------------------------------------------------------------------
    // Writeback
    // ------------------------------------------------------------------------
    assign palu_idone_o    = palu_ivalid_i && (is_pmul ? mul_done : 1'b1);
    assign palu_rd_wdata_o = {32{is_move  }} & (sc == `PALU_SC_GPR2XCR ? gpr_rs1_i
                                                                       : palu_rs1_i) |
                             {32{is_other }} & result_bitwise |
                             {32{is_parith}} & result_parith;
    assign palu_rd_ben_o   = {4{palu_idone_o && ((is_move && wen_move) ||
                                                 is_other || is_parith)}};

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
palu_pkg.sv
palu_adder.sv
palu_shifter.sv
palu_multiplier.sv
palu_share_arb.sv
palu_bitwise.sv
palu_top.sv
palu_assertions.sv
palu_tb.sv
